/* design/zx_consts.svh */
/* port addresses, widths and reset values of the pager
   7FFD is partially decoded, the other ports use the full or low address byte */
`ifndef ZX_CONSTS_SVH
`define ZX_CONSTS_SVH

// widths
`define ZX_PAGE_W 8
`define ZX_NWIN 4

// 128K paging port, selected when a[15] and a[1] are both low
`define ZX_PORT_7FFD_MASK 16'h8002
`define ZX_PORT_7FFD_MATCH 16'h0000

// pentagon config port, full decode
`define ZX_PORT_EFF7 16'hEFF7

// low address bytes of the window ports and the readback port
`define ZX_PORT_ATMWIN_LO 8'h77
`define ZX_PORT_RDBACK_LO 8'hBE

// fixed RAM pages of windows 1 and 2
`define ZX_LEGACY_PAGE1 8'h05
`define ZX_LEGACY_PAGE2 8'h02

// register values after reset
`define ZX_P7FFD_RST 8'h00
`define ZX_PEFF7_RST 8'h00

`endif

/* design/zx_pkg.sv */
/* shared types of the pager
   a window entry is 9 bits, the table holds four of them, window 0 at the low end */
`default_nettype none

`include "zx_consts.svh"

package zx_pkg;

	// decoded I/O port of the current cycle
	typedef enum logic [2:0]
	{
		sel_none   = 3'd0,
		sel_p7ffd  = 3'd1,
		sel_peff7  = 3'd2,
		sel_atmwin = 3'd3,
		sel_rdback = 3'd4
	} port_sel_t;

	// one 16K window of the Z80 address space
	typedef struct packed
	{
		logic                  is_rom;
		logic [`ZX_PAGE_W-1:0] page;
	} win_entry_t;

	// all windows, indexed by a[15:14]
	typedef win_entry_t [`ZX_NWIN-1:0] win_table_t;

endpackage

`default_nettype wire

/* design/port_cmd_if.sv */
/* decoded port commands, all in the fclk domain
   wr_stb is one cycle per I/O write, rd_act stays high for the whole I/O read */
`default_nettype none

interface port_cmd_if;

	logic              wr_stb;
	logic              rd_act;
	zx_pkg::port_sel_t sel;
	logic [1:0]        win;
	logic [7:0]        data;

	// decoder side
	modport src (output wr_stb, output rd_act, output sel, output win, output data);

	// register file side
	modport exec (input wr_stb, input sel, input win, input data);

	// readback side
	modport rdbk (input rd_act, input sel, input win);

endinterface

`default_nettype wire

/* design/bus_decode.sv */
/* Z80 strobes, address and data pass two fclk flops before decoding
   the Z80 must hold a and d_in stable while its strobes are low */
`default_nettype none

`include "zx_consts.svh"

module bus_decode
(
	input  logic        fclk,
	input  logic        reset,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	port_cmd_if.src     cmd,
	output logic        mem_act,
	output logic        mem_wr,
	output logic [1:0]  mem_win
);

	logic [1:0]  iorq_sync;
	logic [1:0]  mreq_sync;
	logic [1:0]  rd_sync;
	logic [1:0]  wr_sync;
	logic [15:0] a_s1, a_s2;
	logic [7:0]  d_s1, d_s2;
	logic        io_wr;
	logic        io_wr_q;

	//////////////////////////////////////////////////
	// synchronizers
	//////////////////////////////////////////////////

	// strobes idle high after reset
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			iorq_sync <= 2'b11;
			mreq_sync <= 2'b11;
			rd_sync   <= 2'b11;
			wr_sync   <= 2'b11;
			io_wr_q   <= 1'b0;
		end
		else
		begin
			iorq_sync <= {iorq_sync[0], iorq_n};
			mreq_sync <= {mreq_sync[0], mreq_n};
			rd_sync   <= {rd_sync[0], rd_n};
			wr_sync   <= {wr_sync[0], wr_n};
			io_wr_q   <= io_wr;
		end
	end

	// address and data keep step with the strobes
	always_ff @(posedge fclk)
	begin
		a_s1 <= a;
		a_s2 <= a_s1;
		d_s1 <= d_in;
		d_s2 <= d_s1;
	end

	//////////////////////////////////////////////////
	// I/O decode
	//////////////////////////////////////////////////

	assign io_wr = ~iorq_sync[1] & ~wr_sync[1];

	// rising edge of the write condition only
	assign cmd.wr_stb = io_wr & ~io_wr_q;
	assign cmd.rd_act = ~iorq_sync[1] & ~rd_sync[1];
	assign cmd.data   = d_s2;

	// EFF7 goes first, it is the only fully decoded port
	always_comb
	begin
		if (a_s2 == `ZX_PORT_EFF7)
			cmd.sel = zx_pkg::sel_peff7;
		else if (a_s2[7:0] == `ZX_PORT_ATMWIN_LO)
			cmd.sel = zx_pkg::sel_atmwin;
		else if (a_s2[7:0] == `ZX_PORT_RDBACK_LO)
			cmd.sel = zx_pkg::sel_rdback;
		else if ((a_s2 & `ZX_PORT_7FFD_MASK) == `ZX_PORT_7FFD_MATCH)
			cmd.sel = zx_pkg::sel_p7ffd;
		else
			cmd.sel = zx_pkg::sel_none;
	end

	// readback picks its window from the high byte low bits
	assign cmd.win = (a_s2[7:0] == `ZX_PORT_RDBACK_LO) ? a_s2[9:8] : a_s2[15:14];

	// memory cycles
	assign mem_act = ~mreq_sync[1];
	assign mem_wr  = ~wr_sync[1];
	assign mem_win = a_s2[15:14];

endmodule

`default_nettype wire

/* design/pager_regs.sv */
/* paging registers, written one cycle after wr_stb
   the 7FFD lock (bit5) is cleared by reset only; window overrides have priority */
`default_nettype none

`include "zx_consts.svh"

module pager_regs
(
	input  logic               fclk,
	input  logic               reset,
	port_cmd_if.exec           cmd,
	output zx_pkg::win_table_t win_table
);

	logic [7:0]                      p7ffd;
	logic [7:0]                      peff7;
	logic [`ZX_NWIN-1:0]             ovr_valid;
	zx_pkg::win_entry_t [`ZX_NWIN-1:0] ovr;

	//////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			p7ffd     <= `ZX_P7FFD_RST;
			peff7     <= `ZX_PEFF7_RST;
			ovr_valid <= '0;
			ovr       <= '0;
		end
		else if (cmd.wr_stb)
		begin
			case (cmd.sel)
				zx_pkg::sel_p7ffd:
				begin
					// 48K lock
					if (!p7ffd[5])
						p7ffd <= cmd.data;
				end
				zx_pkg::sel_peff7:
					peff7 <= cmd.data;
				zx_pkg::sel_atmwin:
				begin
					ovr_valid[cmd.win]   <= 1'b1;
					ovr[cmd.win].is_rom <= ~cmd.data[7];
					ovr[cmd.win].page   <= {1'b0, cmd.data[6:0]};
				end
				default:
				begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// window table
	//////////////////////////////////////////////////

	always_comb
	begin
		// window 0, ROM from 7FFD bit4 or RAM page 0 when EFF7 bit3 is set
		win_table[0].is_rom = ~peff7[3];
		win_table[0].page   = peff7[3] ? '0 : {{(`ZX_PAGE_W-1){1'b0}}, p7ffd[4]};

		win_table[1].is_rom = 1'b0;
		win_table[1].page   = `ZX_LEGACY_PAGE1;

		win_table[2].is_rom = 1'b0;
		win_table[2].page   = `ZX_LEGACY_PAGE2;

		// paged RAM
		win_table[3].is_rom = 1'b0;
		win_table[3].page   = {{(`ZX_PAGE_W-3){1'b0}}, p7ffd[2:0]};

		for (int i = 0; i < `ZX_NWIN; i++)
		begin
			if (ovr_valid[i])
				win_table[i] = ovr[i];
		end
	end

endmodule

`default_nettype wire

/* design/mem_map.sv */
/* registered memory mapping, one cycle behind the synchronized mreq_n
   all outputs are 0 outside memory cycles; ROM windows never get mem_we */
`default_nettype none

`include "zx_consts.svh"

module mem_map
(
	input  logic                  fclk,
	input  logic                  reset,
	input  logic                  mem_act,
	input  logic                  mem_wr,
	input  logic [1:0]            mem_win,
	input  zx_pkg::win_table_t    win_table,
	output logic [`ZX_PAGE_W-1:0] mem_page,
	output logic                  rom_cs,
	output logic                  mem_we
);

	zx_pkg::win_entry_t cur;

	// entry of the addressed window
	assign cur = win_table[mem_win];

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			mem_page <= '0;
			rom_cs   <= 1'b0;
			mem_we   <= 1'b0;
		end
		else if (mem_act)
		begin
			mem_page <= cur.page;
			rom_cs   <= cur.is_rom;
			// write protect for ROM
			mem_we   <= mem_wr & ~cur.is_rom;
		end
		else
		begin
			mem_page <= '0;
			rom_cs   <= 1'b0;
			mem_we   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/port_readback.sv */
/* I/O read data, one cycle behind rd_act
   reads of the readback port and of unused ports are answered, the writable ports are not */
`default_nettype none

module port_readback
(
	input  logic               fclk,
	input  logic               reset,
	port_cmd_if.rdbk           cmd,
	input  zx_pkg::win_table_t win_table,
	output logic [7:0]         d_out,
	output logic               d_oe
);

	zx_pkg::win_entry_t rb;

	assign rb = win_table[cmd.win];

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			d_out <= 8'h00;
			d_oe  <= 1'b0;
		end
		else if (cmd.rd_act)
		begin
			case (cmd.sel)
				zx_pkg::sel_rdback:
				begin
					// same format as a window port write
					d_out <= {~rb.is_rom, rb.page[6:0]};
					d_oe  <= 1'b1;
				end
				zx_pkg::sel_none:
				begin
					d_out <= 8'hFF;
					d_oe  <= 1'b1;
				end
				default:
				begin
					d_out <= 8'h00;
					d_oe  <= 1'b0;
				end
			endcase
		end
		else
		begin
			d_out <= 8'h00;
			d_oe  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/zx_pager.sv */
/* Z80 memory pager, all logic runs on fclk
   the Z80 data bus is split, an external buffer drives d_out onto the bus while d_oe is high */
`default_nettype none

`include "zx_consts.svh"

module zx_pager
(
	input  logic        fclk,
	input  logic        reset,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic [7:0]  d_out,
	output logic        d_oe,
	output logic [7:0]  mem_page,
	output logic        rom_cs,
	output logic        mem_we
);

	logic                                  mem_act;
	logic                                  mem_wr;
	logic [1:0]                            mem_win;
	logic [`ZX_NWIN*(`ZX_PAGE_W+1)-1:0]    win_table;

	port_cmd_if cmd_if();

	//////////////////////////////////////////////////
	// decode, execute, results
	//////////////////////////////////////////////////

	bus_decode bus_decode_inst
	(
		.fclk    (fclk   ),
		.reset   (reset  ),
		.a       (a      ),
		.d_in    (d_in   ),
		.iorq_n  (iorq_n ),
		.mreq_n  (mreq_n ),
		.rd_n    (rd_n   ),
		.wr_n    (wr_n   ),
		.cmd     (cmd_if ),
		.mem_act (mem_act),
		.mem_wr  (mem_wr ),
		.mem_win (mem_win)
	);

	pager_regs pager_regs_inst
	(
		.fclk      (fclk     ),
		.reset     (reset    ),
		.cmd       (cmd_if   ),
		.win_table (win_table)
	);

	mem_map mem_map_inst
	(
		.fclk      (fclk     ),
		.reset     (reset    ),
		.mem_act   (mem_act  ),
		.mem_wr    (mem_wr   ),
		.mem_win   (mem_win  ),
		.win_table (win_table),
		.mem_page  (mem_page ),
		.rom_cs    (rom_cs   ),
		.mem_we    (mem_we   )
	);

	port_readback port_readback_inst
	(
		.fclk      (fclk     ),
		.reset     (reset    ),
		.cmd       (cmd_if   ),
		.win_table (win_table),
		.d_out     (d_out    ),
		.d_oe      (d_oe     )
	);

endmodule

`default_nettype wire

/* test/pager_checker.sv */
/* reference model of the pager, compared against the DUT on the last held cycle
   op codes: 0 I/O write, 1 I/O read, 2 memory read, 3 memory write */
`default_nettype none

`include "zx_consts.svh"

module pager_checker
(
	input  logic        fclk,
	input  logic        reset,
	input  logic        check_now,
	input  int          step,
	input  logic [1:0]  op,
	input  logic [15:0] addr,
	input  logic [7:0]  data,
	input  logic [8:0]  exp,
	input  logic [7:0]  d_out,
	input  logic        d_oe,
	input  logic [7:0]  mem_page,
	input  logic        rom_cs,
	input  logic        mem_we,
	output int          errors
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [1:0] OP_IO_WR  = 2'd0;
	localparam logic [1:0] OP_IO_RD  = 2'd1;
	localparam logic [1:0] OP_MEM_WR = 2'd3;

	logic [7:0]         m7ffd;
	logic [7:0]         meff7;
	logic [3:0]         movr;
	zx_pkg::win_entry_t mwin [4];

	//////////////////////////////////////////////////
	// model
	//////////////////////////////////////////////////

	function automatic zx_pkg::win_entry_t window_entry(input logic [1:0] w);
		zx_pkg::win_entry_t e;
		e.is_rom = 1'b0;
		case (w)
			2'd0:
			begin
				e.is_rom = ~meff7[3];
				e.page   = meff7[3] ? 8'h00 : {7'd0, m7ffd[4]};
			end
			2'd1:
				e.page = `ZX_LEGACY_PAGE1;
			2'd2:
				e.page = `ZX_LEGACY_PAGE2;
			default:
				e.page = {5'd0, m7ffd[2:0]};
		endcase
		if (movr[w])
			e = mwin[w];
		return e;
	endfunction

	// {rom_cs, mem_page} for memory, {d_oe, d_out} for I/O reads
	function automatic logic [8:0] predict(input logic [1:0] o, input logic [15:0] ad);
		zx_pkg::win_entry_t e;
		if (o[1])
		begin
			e = window_entry(ad[15:14]);
			return {e.is_rom, e.page};
		end
		if (o == OP_IO_WR)
			return 9'h000;
		if (ad[7:0] == `ZX_PORT_RDBACK_LO)
		begin
			e = window_entry(ad[9:8]);
			return {1'b1, ~e.is_rom, e.page[6:0]};
		end
		// writable ports keep the bus released
		if (ad == `ZX_PORT_EFF7 || ad[7:0] == `ZX_PORT_ATMWIN_LO ||
			(ad & `ZX_PORT_7FFD_MASK) == `ZX_PORT_7FFD_MATCH)
			return 9'h000;
		return 9'h1FF;
	endfunction

	task automatic apply_write(input logic [15:0] ad, input logic [7:0] dt);
		if (ad == `ZX_PORT_EFF7)
			meff7 = dt;
		else if (ad[7:0] == `ZX_PORT_ATMWIN_LO)
		begin
			movr[ad[15:14]]        = 1'b1;
			mwin[ad[15:14]].is_rom = ~dt[7];
			mwin[ad[15:14]].page   = {1'b0, dt[6:0]};
		end
		else if (ad[7:0] != `ZX_PORT_RDBACK_LO &&
			(ad & `ZX_PORT_7FFD_MASK) == `ZX_PORT_7FFD_MATCH && !m7ffd[5])
			m7ffd = dt;
	endtask

	task automatic compare(input string name, input logic [7:0] want, input logic [7:0] got);
		if (want !== got)
		begin
			errors++;
			$display("Error: %s expected 0x%h got 0x%h at step %0d", name, want, got, step);
		end
	endtask

	//////////////////////////////////////////////////
	// sampling
	//////////////////////////////////////////////////

	always @(negedge fclk)
	begin
		logic [8:0] want;
		if (reset)
		begin
			errors = 0;
			m7ffd  = 8'h00;
			meff7  = 8'h00;
			movr   = 4'h0;
			for (int i = 0; i < 4; i++)
				mwin[i] = '0;
		end
		else if (check_now)
		begin
			want = predict(op, addr);
			if (want !== exp)
			begin
				errors++;
				$display("step %0d: stimulus entry and reference model disagree", step);
			end
			case (op)
				OP_IO_WR:
				begin
					compare("d_oe", 8'h00, {7'd0, d_oe});
					apply_write(addr, data);
				end
				OP_IO_RD:
				begin
					compare("d_oe", {7'd0, exp[8]}, {7'd0, d_oe});
					if (exp[8])
						compare("d_out", exp[7:0], d_out);
				end
				default:
				begin
					compare("rom_cs", {7'd0, exp[8]}, {7'd0, rom_cs});
					compare("mem_page", exp[7:0], mem_page);
					compare("mem_we", {7'd0, (op == OP_MEM_WR) && !exp[8]}, {7'd0, mem_we});
					compare("d_oe", 8'h00, {7'd0, d_oe});
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* test/tb_zx_pager.sv */
/* testbench of the pager, one bus operation per entry
   strobes are held six cycles and released four; window port data is random */
`default_nettype none

`include "zx_consts.svh"

module tb_zx_pager;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 100;
	localparam int NSTEPS = 29;

	localparam logic [1:0] OP_IO_WR  = 2'd0;
	localparam logic [1:0] OP_IO_RD  = 2'd1;
	localparam logic [1:0] OP_MEM_RD = 2'd2;
	localparam logic [1:0] OP_MEM_WR = 2'd3;

	// exp is {rom_cs, mem_page} for memory, {d_oe, d_out} for I/O reads
	typedef struct packed
	{
		logic [1:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [8:0]  exp;
	} step_t;

	step_t       steps [NSTEPS];
	int          n_built;
	int          cur;
	logic [1:0]  cur_op;
	logic [8:0]  cur_exp;
	logic        check_now;
	int          errors;

	logic        fclk;
	logic        reset;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic [7:0]  d_out;
	logic        d_oe;
	logic [7:0]  mem_page;
	logic        rom_cs;
	logic        mem_we;

	always #(PERIOD / 2) fclk = ~fclk;

	zx_pager zx_pager_inst
	(
		.fclk     (fclk    ),
		.reset    (reset   ),
		.a        (a       ),
		.d_in     (d_in    ),
		.iorq_n   (iorq_n  ),
		.mreq_n   (mreq_n  ),
		.rd_n     (rd_n    ),
		.wr_n     (wr_n    ),
		.d_out    (d_out   ),
		.d_oe     (d_oe    ),
		.mem_page (mem_page),
		.rom_cs   (rom_cs  ),
		.mem_we   (mem_we  )
	);

	pager_checker pager_checker_inst
	(
		.fclk      (fclk     ),
		.reset     (reset    ),
		.check_now (check_now),
		.step      (cur      ),
		.op        (cur_op   ),
		.addr      (a        ),
		.data      (d_in     ),
		.exp       (cur_exp  ),
		.d_out     (d_out    ),
		.d_oe      (d_oe     ),
		.mem_page  (mem_page ),
		.rom_cs    (rom_cs   ),
		.mem_we    (mem_we   ),
		.errors    (errors   )
	);

	//////////////////////////////////////////////////
	// stimulus entries
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_step(input logic [1:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [8:0] exp);
		steps[n_built] = {op, addr, data, exp};
		n_built++;
	endtask

	task automatic fill_steps();
		logic [31:0] x;
		logic [7:0]  r;
		x       = 32'd61706;
		n_built = 0;
		// mapping after reset, ROM write blocked
		add_step(OP_MEM_RD, 16'h0000, 8'h00, 9'h100);
		add_step(OP_MEM_RD, 16'h4000, 8'h00, 9'h005);
		add_step(OP_MEM_RD, 16'h8000, 8'h00, 9'h002);
		add_step(OP_MEM_RD, 16'hC000, 8'h00, 9'h000);
		add_step(OP_MEM_WR, 16'h0000, 8'hAA, 9'h100);
		// unused port answers FF, 7FFD stays off the bus
		add_step(OP_IO_RD, 16'h00FE, 8'h00, 9'h1FF);
		add_step(OP_IO_RD, 16'h7FFD, 8'h00, 9'h000);
		// 128K paging, then the lock
		add_step(OP_IO_WR, 16'h7FFD, 8'h13, 9'h000);
		add_step(OP_MEM_RD, 16'hC000, 8'h00, 9'h003);
		add_step(OP_MEM_RD, 16'h0000, 8'h00, 9'h101);
		add_step(OP_IO_WR, 16'h7FFD, 8'h24, 9'h000);
		add_step(OP_IO_WR, 16'h7FFD, 8'h17, 9'h000);
		add_step(OP_MEM_RD, 16'hC000, 8'h00, 9'h004);
		add_step(OP_MEM_RD, 16'h0000, 8'h00, 9'h100);
		// RAM in window 0
		add_step(OP_IO_WR, `ZX_PORT_EFF7, 8'h08, 9'h000);
		add_step(OP_MEM_RD, 16'h0000, 8'h00, 9'h000);
		add_step(OP_MEM_WR, 16'h0000, 8'h55, 9'h000);
		for (int w = 0; w < 4; w++)
		begin
			x = xorshift(x);
			r = x[7:0];
			add_step(OP_IO_WR, {w[1:0], 6'h00, `ZX_PORT_ATMWIN_LO}, r, 9'h000);
			add_step(OP_MEM_RD, {w[1:0], 14'h0100}, 8'h00, {~r[7], 1'b0, r[6:0]});
			add_step(OP_IO_RD, {6'h00, w[1:0], `ZX_PORT_RDBACK_LO}, 8'h00, {1'b1, r});
		end
	endtask

	// one bus operation, six cycles held and four idle
	task automatic run_bus_cycle(input int i);
		@(posedge fclk);
		cur     <= i;
		cur_op  <= steps[i].op;
		cur_exp <= steps[i].exp;
		a       <= steps[i].addr;
		d_in    <= steps[i].data;
		case (steps[i].op)
			OP_IO_WR:
			begin
				iorq_n <= 1'b0;
				wr_n   <= 1'b0;
			end
			OP_IO_RD:
			begin
				iorq_n <= 1'b0;
				rd_n   <= 1'b0;
			end
			OP_MEM_RD:
			begin
				mreq_n <= 1'b0;
				rd_n   <= 1'b0;
			end
			default:
			begin
				mreq_n <= 1'b0;
				wr_n   <= 1'b0;
			end
		endcase
		repeat (5) @(posedge fclk);
		check_now <= 1'b1;
		@(posedge fclk);
		check_now <= 1'b0;
		iorq_n    <= 1'b1;
		mreq_n    <= 1'b1;
		rd_n      <= 1'b1;
		wr_n      <= 1'b1;
		repeat (3) @(posedge fclk);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		fclk      = 1'b0;
		reset     = 1'b1;
		a         = 16'h0000;
		d_in      = 8'h00;
		iorq_n    = 1'b1;
		mreq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		check_now = 1'b0;
		cur       = 0;
		cur_op    = 2'd0;
		cur_exp   = 9'h000;
		fill_steps();
		repeat (2) @(posedge fclk);
		reset <= 1'b0;
		for (int i = 0; i < NSTEPS; i++)
			run_bus_cycle(i);
		@(posedge fclk);
		$display("bus operations %0d, errors %0d", NSTEPS, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(NSTEPS * 12 * PERIOD);
		$display("watchdog expired before all bus operations were applied");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* zx_pager.f */
+incdir+design
design/zx_pkg.sv
design/port_cmd_if.sv
design/bus_decode.sv
design/pager_regs.sv
design/mem_map.sv
design/port_readback.sv
design/zx_pager.sv
test/pager_checker.sv
test/tb_zx_pager.sv

/* Makefile */
# Verilator build and run of the pager testbench

VERILATOR  ?= verilator
TOP        ?= tb_zx_pager
FLIST      ?= zx_pager.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/100ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) design/*.sv design/*.svh test/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
